//--- hdl/vga_reg_pkg.sv
/* Amplifier-side register map and host gain word for the VGA gain subsystem.
   Imported by the register block, the top level, the frame package and the testbench. */
`default_nettype none

package vga_reg_pkg;

  // width of the attenuation code in the gain control register
  localparam int ATTEN_BITS = 6;

  // amplifier register addresses are 7 bits wide on the SPI bus
  localparam int REG_ADDR_BITS = 7;

  // gain control register of the amplifier
  localparam logic [REG_ADDR_BITS-1:0] GAIN_REG_ADDR = 7'd2;

  // one channel's gain setting as the host sees it
  // power_down sits above the attenuation code, as in the amplifier register
  typedef struct packed {
    logic                  power_down;
    logic [ATTEN_BITS-1:0] atten;
  } gain_word_t;

  // shadow value after reset and for reads of a missing channel
  localparam gain_word_t GAIN_RESET = '0;

  // width of the host channel index
  // a single channel still gets one address bit
  function automatic int chan_bits(input int num_channels);
    if (num_channels > 1) begin
      return $clog2(num_channels);
    end
    return 1;
  endfunction

endpackage : vga_reg_pkg

`default_nettype wire

//--- hdl/spi_frame_pkg.sv
/* Layout of the 16-bit SPI frame sent to each amplifier.
   The union gives a raw view for the shifter and a gain view for frame building. */
`default_nettype none

package spi_frame_pkg;
  import vga_reg_pkg::*;

  // bits per SPI frame, MSB first on the wire
  localparam int FRAME_BITS = 16;

  // data byte of an amplifier register
  localparam int REG_DATA_BITS = 8;

  // rw bit value for a register write, reads are never issued
  localparam logic RW_WRITE = 1'b0;

  // generic register access as the amplifier decodes it
  typedef struct packed {
    logic                     rw;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    logic [REG_DATA_BITS-1:0] reg_data;
  } raw_frame_t;

  // gain register access, data byte split into reserved bit and gain word
  typedef struct packed {
    logic                     rw;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    logic                     rsvd;
    gain_word_t               gain;
  } gain_frame_t;

  // same 16 bits, two decodings
  typedef union packed {
    raw_frame_t  raw;
    gain_frame_t gain;
  } vga_frame_u;

endpackage : spi_frame_pkg

`default_nettype wire

//--- hdl/vga_cmd_if.sv
/* Command channel from the frame scheduler to the SPI master.
   Valid/ready handshake, one frame plus its target channel per transfer. */
`timescale 1ns/1ps
`default_nettype none

interface vga_cmd_if
  import vga_reg_pkg::*, spi_frame_pkg::*;
#(
  parameter int NUM_CHANNELS = 4
) ();

  localparam int CH_BITS = chan_bits(NUM_CHANNELS);

  // transfer on a clock edge with valid and ready both high
  logic               valid;
  logic               ready;
  vga_frame_u         frame;
  // index of the chip select to drive for this frame
  logic [CH_BITS-1:0] channel;

  // scheduler side
  modport src (output valid, output frame, output channel, input ready);

  // serial master side
  modport dst (input valid, input frame, input channel, output ready);

endinterface : vga_cmd_if

`default_nettype wire

//--- hdl/vga_gain_regs.sv
/* Shadow gain registers with dirty flags, host read-back and a round-robin scheduler.
   Each dirty channel becomes one gain-register write frame on the command interface. */
`timescale 1ns/1ps
`default_nettype none

module vga_gain_regs
  import vga_reg_pkg::*, spi_frame_pkg::*;
#(
  parameter int NUM_CHANNELS = 4
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 reg_wr,
  input  wire  [chan_bits(NUM_CHANNELS)-1:0]  reg_addr,
  input  wire  gain_word_t                    reg_wdata,
  input  wire                                 master_idle,
  output gain_word_t                          reg_rdata,
  output logic                                pending,
  vga_cmd_if.src                              cmd
);

  localparam int CH_BITS = chan_bits(NUM_CHANNELS);

  gain_word_t               shadow [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0]  dirty;

  // round-robin pointer, last channel handed to the master
  logic [CH_BITS-1:0]       last_ch;
  logic [CH_BITS-1:0]       pick;
  logic                     found;

  // set when the channel in flight is written again before its transfer
  logic                     rewritten;

  logic                     wr_ok;
  logic                     xfer;
  gain_frame_t              next_frame;

  // writes outside the channel range are dropped
  assign wr_ok = reg_wr && (int'(reg_addr) < NUM_CHANNELS);
  assign xfer  = cmd.valid && cmd.ready;

  // host read-back, purely combinational
  always_comb begin
    reg_rdata = GAIN_RESET;
    if (int'(reg_addr) < NUM_CHANNELS) begin
      reg_rdata = shadow[reg_addr];
    end
  end

  // shadow values and dirty flags
  always_ff @(posedge clk) begin
    if (reset) begin
      dirty <= '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        shadow[i] <= GAIN_RESET;
      end
    end else begin
      // frame delivered, unless a newer value arrived while it waited
      if (xfer && !rewritten) begin
        dirty[cmd.channel] <= 1'b0;
      end
      // a write on the transfer edge wins over the clear above
      if (wr_ok) begin
        shadow[reg_addr] <= reg_wdata;
        dirty[reg_addr]  <= 1'b1;
      end
    end
  end

  // search from the channel after the last one served
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last_ch;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      idx = (int'(last_ch) + i) % NUM_CHANNELS;
      if (!found && dirty[idx]) begin
        found = 1'b1;
        pick  = CH_BITS'(idx);
      end
    end
  end

  // gain view of the outgoing frame
  always_comb begin
    next_frame          = '0;
    next_frame.rw       = RW_WRITE;
    next_frame.reg_addr = GAIN_REG_ADDR;
    next_frame.rsvd     = 1'b0;
    next_frame.gain     = shadow[pick];
  end

  // scheduler control
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.valid <= 1'b0;
      rewritten <= 1'b0;
      // so that channel 0 is searched first
      last_ch   <= CH_BITS'(NUM_CHANNELS - 1);
    end else begin
      if (!cmd.valid && found) begin
        cmd.valid <= 1'b1;
        last_ch   <= pick;
        // a write on this edge postdates the captured payload
        rewritten <= wr_ok && (reg_addr == pick);
      end else if (xfer) begin
        cmd.valid <= 1'b0;
      end else if (cmd.valid && wr_ok && (reg_addr == cmd.channel)) begin
        rewritten <= 1'b1;
      end
    end
  end

  // payload is only loaded while valid is low, so it holds until the transfer
  always_ff @(posedge clk) begin
    if (!cmd.valid && found) begin
      cmd.frame.gain <= next_frame;
      cmd.channel    <= pick;
    end
  end

  // busy while anything is queued, offered or on the wire
  assign pending = (|dirty) || cmd.valid || !master_idle;

endmodule : vga_gain_regs

`default_nettype wire

//--- hdl/vga_spi_master.sv
/* Write-only SPI master for a bank of amplifiers with one chip select each.
   Divides clk into a free-running SCK and shifts 16-bit frames MSB first on falling SCK. */
`timescale 1ns/1ps
`default_nettype none

module vga_spi_master
  import vga_reg_pkg::*, spi_frame_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int CLK_DIV      = 8
) (
  input  wire                      clk,
  input  wire                      reset,
  vga_cmd_if.dst                   cmd,
  output logic                     sck,
  output logic                     sdi,
  output logic [NUM_CHANNELS-1:0]  cs_n
);

  // sck toggles every CLK_DIV/2 system clocks
  localparam int HALF_DIV = CLK_DIV / 2;
  localparam int CNT_BITS = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
  localparam logic [CNT_BITS-1:0] CNT_MAX = CNT_BITS'(HALF_DIV - 1);

  localparam int CH_BITS      = chan_bits(NUM_CHANNELS);
  localparam int BIT_CNT_BITS = $clog2(FRAME_BITS);
  localparam logic [BIT_CNT_BITS-1:0] LAST_BIT = BIT_CNT_BITS'(FRAME_BITS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_FINISH
  } state_t;

  state_t                   state;
  logic [CNT_BITS-1:0]      div_cnt;
  logic                     sck_fall;
  logic [BIT_CNT_BITS-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0]    shreg;
  logic [CH_BITS-1:0]       chan;
  raw_frame_t               load_frame;
  logic                     xfer;

  // clock divider, sck runs whether or not a frame is active
  always_ff @(posedge clk) begin
    if (reset) begin
      sck     <= 1'b0;
      div_cnt <= '0;
    end else if (div_cnt == CNT_MAX) begin
      sck     <= ~sck;
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // true on the clk edge where sck goes from high to low
  assign sck_fall = sck && (div_cnt == CNT_MAX);

  // accept a command only between frames
  assign cmd.ready = (state == S_IDLE);
  assign xfer      = cmd.valid && cmd.ready;

  // raw view of the frame, rw forced to write so no amplifier ever drives back
  always_comb begin
    load_frame    = cmd.frame.raw;
    load_frame.rw = RW_WRITE;
  end

  // frame payload and target channel
  always_ff @(posedge clk) begin
    if (xfer) begin
      shreg <= load_frame;
      chan  <= cmd.channel;
    end else if (state == S_SHIFT && sck_fall) begin
      shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
      cs_n    <= '1;
      sdi     <= 1'b0;
    end else begin
      unique case (state)
        S_IDLE: begin
          if (xfer) begin
            state   <= S_SHIFT;
            bit_cnt <= '0;
          end
        end
        S_SHIFT: begin
          // first falling edge selects the amplifier and presents bit 15
          if (sck_fall) begin
            cs_n[chan] <= 1'b0;
            sdi        <= shreg[FRAME_BITS-1];
            bit_cnt    <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= S_FINISH;
            end
          end
        end
        S_FINISH: begin
          // last bit has been sampled on the rising edge before this one
          if (sck_fall) begin
            cs_n  <= '1;
            sdi   <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
          cs_n  <= '1;
        end
      endcase
    end
  end

endmodule : vga_spi_master

`default_nettype wire

//--- hdl/vga_gain_top.sv
/* Top level of the VGA gain-control subsystem.
   Host register port in, shared SPI bus with one chip select per amplifier out. */
`timescale 1ns/1ps
`default_nettype none

module vga_gain_top
  import vga_reg_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  // system clocks per sck period, even
  parameter int CLK_DIV      = 8
) (
  input  wire                                 clk,
  input  wire                                 reset,
  // host register port
  input  wire                                 reg_wr,
  input  wire  [chan_bits(NUM_CHANNELS)-1:0]  reg_addr,
  input  wire  gain_word_t                    reg_wdata,
  output gain_word_t                          reg_rdata,
  output logic                                pending,
  // SPI bus to the amplifiers
  output logic                                sck,
  output logic                                sdi,
  output logic [NUM_CHANNELS-1:0]             cs_n
);

  // frame handoff between scheduler and serial master
  vga_cmd_if #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) cmd_bus ();

  // shadow registers and frame scheduler
  vga_gain_regs #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_regs (
    .clk         (clk),
    .reset       (reset),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    // master ready doubles as its idle indication
    .master_idle (cmd_bus.ready),
    .reg_rdata   (reg_rdata),
    .pending     (pending),
    .cmd         (cmd_bus.src)
  );

  // sck divider and shift engine
  vga_spi_master #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CLK_DIV      (CLK_DIV)
  ) u_spi (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd_bus.dst),
    .sck   (sck),
    .sdi   (sdi),
    .cs_n  (cs_n)
  );

endmodule : vga_gain_top

`default_nettype wire

//--- verif/vga_gain_assert.sv
/* SPI protocol and command handshake assertions, bound into the gain subsystem top.
   Watches the chip selects, the SDI timing and the scheduler to master handoff. */
`timescale 1ns/1ps
`default_nettype none

module vga_gain_assert
  import spi_frame_pkg::*;
#(
  parameter int NUM_CHANNELS = 4
) (
  input wire                    clk,
  input wire                    reset,
  input wire                    sck,
  input wire                    sdi,
  input wire [NUM_CHANNELS-1:0] cs_n,
  input wire                    valid,
  input wire                    ready,
  input wire [FRAME_BITS-1:0]   frame
);

  // shared bus, never two amplifiers selected
  one_cs_low: assert property (@(posedge clk) disable iff (reset) $countones(~cs_n) <= 1)
    else $error("more than one chip select low");

  // data moves on falling sck, or freely while the bus is deselected
  sdi_on_fall: assert property (@(posedge clk) disable iff (reset)
    $changed(sdi) |-> ($fell(sck) || (&cs_n)))
    else $error("sdi changed away from a falling sck edge");

  // offered frame held until the master takes it
  valid_hold: assert property (@(posedge clk) disable iff (reset)
    (valid && !ready) |=> (valid && $stable(frame)))
    else $error("valid dropped or frame changed before ready");

  cs_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> (&cs_n))
    else $error("chip select low during reset");

endmodule : vga_gain_assert

bind vga_gain_top vga_gain_assert #(
  .NUM_CHANNELS (NUM_CHANNELS)
) u_assert (
  .clk   (clk),
  .reset (reset),
  .sck   (sck),
  .sdi   (sdi),
  .cs_n  (cs_n),
  .valid (cmd_bus.valid),
  .ready (cmd_bus.ready),
  .frame (cmd_bus.frame)
);

`default_nettype wire

//--- verif/vga_gain_tb.sv
/* Testbench for the VGA gain subsystem, driven from a table of host writes applied in groups.
   Captures every SPI frame per chip select and compares it with the gains written. */
`timescale 1ns/1ps
`default_nettype none

module vga_gain_tb
  import vga_reg_pkg::*, spi_frame_pkg::*;
();

  localparam int NUM_CHANNELS = 4;
  localparam int CLK_DIV      = 8;
  localparam int CH_BITS      = chan_bits(NUM_CHANNELS);
  // generous bound on clocks for a queue of frames to drain
  localparam int IDLE_TIMEOUT = 20 * CLK_DIV * 4 * NUM_CHANNELS;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    reg_wr;
  logic [CH_BITS-1:0]      reg_addr;
  gain_word_t              reg_wdata;
  gain_word_t              reg_rdata;
  logic                    pending;
  logic                    sck;
  logic                    sdi;
  logic [NUM_CHANNELS-1:0] cs_n;

  // stimulus table, one row per host write
  int                      stim_grp[$];
  int                      stim_ch[$];
  gain_word_t              stim_gain[$];
  string                   stim_name[$];

  // last value written per channel and the row that wrote it
  gain_word_t              exp_shadow [NUM_CHANNELS] = '{default: '0};
  string                   exp_name [NUM_CHANNELS] = '{default: "reset"};
  int                      base_frames [NUM_CHANNELS];
  int                      base_total;
  int                      error_count = 0;

  // frame capture state
  vga_frame_u              last_frame [NUM_CHANNELS] = '{default: '0};
  int                      chan_frames [NUM_CHANNELS] = '{default: 0};
  int                      total_frames = 0;
  logic [FRAME_BITS-1:0]   shift_word = '0;
  int                      shift_bits = 0;
  logic [NUM_CHANNELS-1:0] prev_cs_n = '1;
  logic                    prev_sck = 1'b0;

  vga_gain_top #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CLK_DIV      (CLK_DIV)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .pending   (pending),
    .sck       (sck),
    .sdi       (sdi),
    .cs_n      (cs_n)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // bus sampled mid-cycle, where nothing is changing
  always @(negedge clk) begin
    int low_ch;
    low_ch = -1;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (cs_n[i] === 1'b0) begin
        low_ch = i;
      end
    end
    // chip select just went low, new frame
    if (low_ch >= 0 && prev_cs_n[low_ch] === 1'b1) begin
      shift_bits = 0;
      shift_word = '0;
    end
    // one bit per rising sck while exactly one amplifier is selected
    if (sck === 1'b1 && prev_sck === 1'b0 && $countones(~cs_n) == 1) begin
      shift_word = {shift_word[FRAME_BITS-2:0], sdi};
      shift_bits++;
    end
    // rise of the chip select ends the frame
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (prev_cs_n[i] === 1'b0 && cs_n[i] === 1'b1) begin
        if (shift_bits != FRAME_BITS) begin
          abort_run($sformatf("frame on channel %0d carried %0d bits instead of %0d",
                              i, shift_bits, FRAME_BITS));
        end
        last_frame[i] = shift_word;
        chan_frames[i]++;
        total_frames++;
      end
    end
    prev_cs_n = cs_n;
    prev_sck  = sck;
  end

  task automatic check_gain(input string name, input gain_word_t exp, input gain_word_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  // rw, address and reserved bit are fixed for a gain write
  task automatic check_frame(input string name, input gain_word_t exp, input vga_frame_u act);
    if (act.gain.rw !== 1'b0 || act.gain.reg_addr !== GAIN_REG_ADDR || act.gain.rsvd !== 1'b0) begin
      abort_run($sformatf("MISMATCH %s expected rw 0 addr %h rsvd 0 actual rw %b addr %h rsvd %b",
                          name, GAIN_REG_ADDR, act.gain.rw, act.gain.reg_addr, act.gain.rsvd));
    end
    check_gain(name, exp, act.gain.gain);
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_level(input string name, input logic [NUM_CHANNELS-1:0] exp,
                             input logic [NUM_CHANNELS-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic void add_stim(input int grp, input int ch, input gain_word_t gain,
                                   input string name);
    stim_grp.push_back(grp);
    stim_ch.push_back(ch);
    stim_gain.push_back(gain);
    stim_name.push_back(name);
  endfunction

  task automatic build_table();
    logic [31:0] rnd;
    int          burst_ch [8] = '{0, 3, 1, 1, 1, 2, 1, 3};
    add_stim(1, 2, 7'b0_010001, "single_ch2");
    // every channel on consecutive cycles
    add_stim(2, 0, 7'b0_000101, "b2b_ch0");
    add_stim(2, 1, 7'b1_111111, "b2b_ch1");
    add_stim(2, 2, 7'b0_101010, "b2b_ch2");
    add_stim(2, 3, 7'b1_000000, "b2b_ch3");
    // random gains, channel 1 hammered while the others queue
    for (int i = 0; i < 8; i++) begin
      rnd = $urandom;
      add_stim(3, burst_ch[i], rnd[6:0], $sformatf("rand_%0d_ch%0d", i, burst_ch[i]));
    end
  endtask

  // rows of one group go out on back-to-back cycles
  task automatic apply_group(input int grp);
    foreach (stim_grp[i]) begin
      if (stim_grp[i] == grp) begin
        step();
        reg_wr                 = 1'b1;
        reg_addr               = CH_BITS'(stim_ch[i]);
        reg_wdata              = stim_gain[i];
        exp_shadow[stim_ch[i]] = stim_gain[i];
        exp_name[stim_ch[i]]   = stim_name[i];
      end
    end
    step();
    reg_wr = 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    while (pending !== 1'b0) begin
      if (cycles >= IDLE_TIMEOUT) begin
        abort_run($sformatf("timeout, pending never fell after %s", name));
      end
      step();
      cycles++;
    end
    // frame monitor samples on falling clk and still owes the last chip select rise
    step();
  endtask

  task automatic check_readback(input string name);
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      step();
      reg_addr = CH_BITS'(ch);
      #2;
      check_gain($sformatf("%s ch%0d", name, ch), exp_shadow[ch], reg_rdata);
    end
  endtask

  task automatic snapshot();
    base_frames = chan_frames;
    base_total  = total_frames;
  endtask

  initial begin
    void'($urandom(32'h6960));
    reset     = 1'b1;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    check_level("reset cs_n", '1, cs_n);
    check_level("reset pending", '0, {{(NUM_CHANNELS-1){1'b0}}, pending});
    check_readback("reset readback");

    // one write, one frame on that channel only
    snapshot();
    apply_group(1);
    wait_idle("single write");
    check_count("single total frames", base_total + 1, total_frames);
    check_count("single ch2 frames", base_frames[2] + 1, chan_frames[2]);
    check_frame(exp_name[2], exp_shadow[2], last_frame[2]);
    check_readback("single readback");

    snapshot();
    apply_group(2);
    wait_idle("back-to-back writes");
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      check_count($sformatf("b2b ch%0d frames", ch), base_frames[ch] + 1, chan_frames[ch]);
      check_frame(exp_name[ch], exp_shadow[ch], last_frame[ch]);
    end
    check_readback("b2b readback");

    // rewrites may merge, only the newest value has to arrive
    snapshot();
    apply_group(3);
    wait_idle("random rewrites");
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (chan_frames[ch] == base_frames[ch]) begin
        abort_run($sformatf("no frame reached channel %0d after random rewrites", ch));
      end
      check_frame(exp_name[ch], exp_shadow[ch], last_frame[ch]);
    end
    check_readback("random readback");

    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run("errors were recorded during the run");
    end
  end

endmodule : vga_gain_tb

`default_nettype wire

//--- verilog.f
hdl/vga_reg_pkg.sv
hdl/spi_frame_pkg.sv
hdl/vga_cmd_if.sv
hdl/vga_gain_regs.sv
hdl/vga_spi_master.sv
hdl/vga_gain_top.sv
verif/vga_gain_assert.sv
verif/vga_gain_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vga_gain_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a pass line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
